//--- Makefile
# Verilator build and run of the vertical box filter testbench

VERILATOR ?= verilator
VFLAGS    ?= --assert -Wno-fatal
TOP       ?= tb_vfilter
BUILD_DIR ?= build
FILELIST  ?= src.f
PASS_TEXT := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR VFLAGS TOP BUILD_DIR"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

test: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_TEXT)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- src.f
src/vfilt_pkg.sv
src/tap_bus_if.sv
src/line_buffer.sv
src/window_buffer_9.sv
src/column_sum_9.sv
src/vfilter_top.sv
verification/tb_vfilter.sv

//--- src/column_sum_9.sv
`timescale 1ns/1ps

module column_sum_9 (
  input  logic            clk,
  input  logic            rst_n_i,
  tap_bus_if.consumer     taps,
  output vfilt_pkg::sum_t sum_o,
  output logic            sum_valid_o,
  output logic            row_first_o
);

  // stage 1 holds three partial sums of three taps each
  vfilt_pkg::sum_t part_q [3];
  logic            s1_valid_q;
  logic            s1_first_q;

  vfilt_pkg::sum_t sum_q;
  logic            sum_valid_q;
  logic            row_first_q;

  logic            set_valid;

  // the chain fills top down, so the deepest tap decides when a set is complete
  assign set_valid = taps.tap_valid[vfilt_pkg::N_TAPS-1];

  always_ff @(posedge clk) begin
    if (set_valid) begin
      for (int g = 0; g < 3; g++) begin
        part_q[g] <= vfilt_pkg::sum_t'(taps.taps[3*g])
                   + vfilt_pkg::sum_t'(taps.taps[3*g+1])
                   + vfilt_pkg::sum_t'(taps.taps[3*g+2]);
      end
    end
    if (s1_valid_q) begin
      sum_q <= part_q[0] + part_q[1] + part_q[2];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      s1_first_q  <= 1'b0;
      sum_valid_q <= 1'b0;
      row_first_q <= 1'b0;
    end else begin
      s1_valid_q  <= set_valid;
      s1_first_q  <= set_valid & taps.tap_first;
      sum_valid_q <= s1_valid_q;
      row_first_q <= s1_first_q;
    end
  end

  assign sum_o       = sum_q;
  assign sum_valid_o = sum_valid_q;
  assign row_first_o = row_first_q;

  ap_first_is_valid: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    row_first_o |-> sum_valid_o
  ) else $error("column_sum_9: row marker on an invalid output");

endmodule

//--- src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  vfilt_pkg::pixel_t    pix_i,
  input  logic                 pix_valid_i,
  input  vfilt_pkg::img_size_t img_size_i,
  output vfilt_pkg::pixel_t    pix_o,
  output logic                 pix_valid_o,
  output logic                 row_first_o
);

  vfilt_pkg::pixel_t    mem [vfilt_pkg::MAX_WIDTH];
  vfilt_pkg::col_addr_t wr_ptr;
  vfilt_pkg::col_addr_t last_col;
  logic                 at_last;
  logic                 filled;

  assign last_col = vfilt_pkg::col_addr_t'(img_size_i - 1'b1);
  assign at_last  = (wr_ptr == last_col);

  // the entry under the write pointer is exactly one row old until it is overwritten
  assign pix_o       = mem[wr_ptr];
  assign pix_valid_o = pix_valid_i & filled;

  // pointer zero means the sample leaving the buffer is column 0
  assign row_first_o = pix_valid_o & (wr_ptr == '0);

  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      mem[wr_ptr] <= pix_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      filled <= 1'b0;
    end else if (pix_valid_i) begin
      if (at_last) begin
        // one whole row has been stored once the pointer wraps for the first time
        wr_ptr <= '0;
        filled <= 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  ap_size_range: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (img_size_i >= 1) && (img_size_i <= vfilt_pkg::MAX_WIDTH)
  ) else $error("line_buffer: row length %0d out of range", img_size_i);

  // also catches a row length that shrinks below the stored pointer
  ap_ptr_bound: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wr_ptr < img_size_i
  ) else $error("line_buffer: write pointer %0d beyond row length %0d",
                wr_ptr, img_size_i);

  ap_valid_follows_input: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $rose(pix_valid_o) |-> pix_valid_i && filled
  ) else $error("line_buffer: output valid rose without an input sample");

endmodule

//--- src/tap_bus_if.sv
`timescale 1ns/1ps

interface tap_bus_if;

  // taps[0] is the live pixel, taps[k] is the same column k rows up
  vfilt_pkg::pixel_t             taps [vfilt_pkg::N_TAPS];

  // one bit per tap, set while that tap holds a real pixel
  logic [vfilt_pkg::N_TAPS-1:0]  tap_valid;

  // high on column 0 of a row once all taps are valid
  logic                          tap_first;

  modport producer (
    output taps,
    output tap_valid,
    output tap_first
  );

  modport consumer (
    input taps,
    input tap_valid,
    input tap_first
  );

endinterface

//--- src/vfilt_pkg.sv
package vfilt_pkg;

  // widths that the typedefs below are built from
  localparam int PIX_W  = 8;
  localparam int SUM_W  = 12;
  localparam int SIZE_W = 9;

  // number of vertical taps and the line buffers that produce them
  localparam int N_TAPS  = 9;
  localparam int N_LINES = 8;

  // longest row, also the depth of every line buffer memory
  localparam int MAX_WIDTH = 511;

  // one greyscale sample
  typedef logic [PIX_W-1:0] pixel_t;

  // nine full-scale pixels add up to 2295, which fits in 12 bits
  typedef logic [SUM_W-1:0] sum_t;

  // row length in pixels
  typedef logic [SIZE_W-1:0] img_size_t;

  // column index inside a line buffer
  typedef logic [SIZE_W-1:0] col_addr_t;

endpackage

//--- src/vfilter_top.sv
`timescale 1ns/1ps

module vfilter_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  vfilt_pkg::img_size_t img_size_i,
  input  vfilt_pkg::pixel_t    pix_i,
  input  logic                 pix_valid_i,
  output vfilt_pkg::sum_t      sum_o,
  output logic                 sum_valid_o,
  output logic                 row_first_o
);

  // nine aligned taps, no handshake since the stream is never stalled
  tap_bus_if tap_bus ();

  window_buffer_9 u_window_buffer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .img_size_i  (img_size_i),
    .taps        (tap_bus.producer)
  );

  column_sum_9 u_column_sum (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .taps        (tap_bus.consumer),
    .sum_o       (sum_o),
    .sum_valid_o (sum_valid_o),
    .row_first_o (row_first_o)
  );

endmodule

//--- src/window_buffer_9.sv
`timescale 1ns/1ps

module window_buffer_9 (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  vfilt_pkg::pixel_t    pix_i,
  input  logic                 pix_valid_i,
  input  vfilt_pkg::img_size_t img_size_i,
  tap_bus_if.producer          taps
);

  // chain_pix[k] feeds line buffer k, chain_pix[k+1] is what it returns
  vfilt_pkg::pixel_t              chain_pix [vfilt_pkg::N_TAPS];
  logic [vfilt_pkg::N_TAPS-1:0]   chain_valid;
  logic [vfilt_pkg::N_LINES-1:0]  line_first;

  assign chain_pix[0]   = pix_i;
  assign chain_valid[0] = pix_valid_i;

  generate
    for (genvar k = 0; k < vfilt_pkg::N_LINES; k++) begin : gen_lines
      line_buffer u_line_buffer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pix_i       (chain_pix[k]),
        .pix_valid_i (chain_valid[k]),
        .img_size_i  (img_size_i),
        .pix_o       (chain_pix[k+1]),
        .pix_valid_o (chain_valid[k+1]),
        .row_first_o (line_first[k])
      );

      // a deeper buffer only fills after the one above it
      ap_fill_order: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        chain_valid[k+1] |-> chain_valid[k]
      ) else $error("window_buffer_9: tap %0d valid before tap %0d", k + 1, k);

      // every buffer that emits must point at the same column as the first one
      ap_col_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        chain_valid[k+1] |-> (line_first[k] == line_first[0])
      ) else $error("window_buffer_9: line %0d column out of step", k);
    end

    for (genvar t = 0; t < vfilt_pkg::N_TAPS; t++) begin : gen_taps
      assign taps.taps[t] = chain_pix[t];
    end
  endgenerate

  assign taps.tap_valid = chain_valid;

  // the last buffer only marks a row once all nine taps carry data
  assign taps.tap_first = line_first[vfilt_pkg::N_LINES-1];

endmodule

//--- verification/tb_vfilter.sv
`timescale 1ns/1ps

module tb_vfilter;

  localparam time CLK_PERIOD  = 20;
  localparam time HALF_PERIOD = CLK_PERIOD / 2;
  localparam int  IMG_ROWS    = 16;
  localparam int  IMG_COLS    = 64;

  // pixel count over all tests below, used to size the watchdog
  localparam int TOTAL_PIXELS    = 16*9 + 16*14 + 16*14 + 5*12 + 37*11 + 16*10;
  localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 3 + 1000;

  logic                 clk;
  logic                 rst_n_i;
  vfilt_pkg::img_size_t img_size_i;
  vfilt_pkg::pixel_t    pix_i;
  logic                 pix_valid_i;
  vfilt_pkg::sum_t      sum_o;
  logic                 sum_valid_o;
  logic                 row_first_o;

  vfilt_pkg::pixel_t img [IMG_ROWS][IMG_COLS];
  vfilt_pkg::sum_t   exp_sum_q [$];
  logic              exp_first_q [$];
  time               exp_time_q [$];

  logic [31:0] lfsr_state = 32'h86fc73bf;
  int          error_count = 0;
  int          check_count = 0;
  int          out_count = 0;
  int          test_count = 0;
  int          failed_tests = 0;

  vfilter_top DUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .img_size_i  (img_size_i),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .sum_o       (sum_o),
    .sum_valid_o (sum_valid_o),
    .row_first_o (row_first_o)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  // column sum over the given row and the eight rows above it
  function automatic vfilt_pkg::sum_t ref_sum(input int row, input int col);
    vfilt_pkg::sum_t acc;
    acc = '0;
    for (int k = 0; k < vfilt_pkg::N_TAPS; k++) begin
      acc = acc + vfilt_pkg::sum_t'(img[row-k][col]);
    end
    return acc;
  endfunction

  task automatic check_sum(input string name, input vfilt_pkg::sum_t exp_v,
                           input vfilt_pkg::sum_t act_v);
    check_count++;
    if (exp_v !== act_v) begin
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    check_count++;
    if (exp_v !== act_v) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
      error_count++;
    end
  endtask

  initial begin : compare_proc
    vfilt_pkg::sum_t exp_sum;
    logic            exp_first;
    time             in_time;
    forever begin
      @(posedge clk);
      if (sum_valid_o === 1'b1) begin
        out_count++;
        if (exp_sum_q.size() == 0) begin
          $display("unexpected output at %0t: sum_valid_o is high with no pending input",
                   $time);
          error_count++;
        end else begin
          exp_sum   = exp_sum_q.pop_front();
          exp_first = exp_first_q.pop_front();
          in_time   = exp_time_q.pop_front();
          check_sum("sum_o", exp_sum, sum_o);
          check_flag("row_first_o", exp_first, row_first_o);
          check_count++;
          if ($time - in_time != 2 * CLK_PERIOD) begin
            $display("CHECK FAILED at %0t: sum_valid_o latency expected %0t, got %0t",
                     $time, 2 * CLK_PERIOD, $time - in_time);
            error_count++;
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic apply_reset(input int width);
    @(negedge clk);
    rst_n_i     = 1'b0;
    pix_valid_i = 1'b0;
    pix_i       = '0;
    img_size_i  = vfilt_pkg::img_size_t'(width);
    exp_sum_q.delete();
    exp_first_q.delete();
    exp_time_q.delete();
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_sum_q.size() != 0 && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (exp_sum_q.size() != 0) begin
      $display("test %s: %0d expected sums never appeared", name, exp_sum_q.size());
      error_count++;
    end
  endtask

  task automatic run_test(input string name, input int width, input int rows,
                          input bit gaps, input bit full_scale);
    int         errors_before;
    logic [7:0] pix;
    errors_before = error_count;
    apply_reset(width);
    out_count = 0;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < width; c++) begin
        // both bits zero gives an idle cycle about one time in four
        if (gaps) begin
          while (random_bits(2) == 8'd0) begin
            @(negedge clk);
            pix_valid_i = 1'b0;
          end
        end
        pix = full_scale ? 8'hff : random_bits(8);
        img[r][c] = pix;
        @(negedge clk);
        pix_i       = pix;
        pix_valid_i = 1'b1;
        if (r >= vfilt_pkg::N_LINES) begin
          exp_sum_q.push_back(ref_sum(r, c));
          exp_first_q.push_back(c == 0);
          exp_time_q.push_back($time + HALF_PERIOD);
        end
      end
    end
    @(negedge clk);
    pix_valid_i = 1'b0;
    wait_drain(name);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: passed, %0d outputs", name, out_count);
    end else begin
      $display("test %s: failed, %0d errors", name, error_count - errors_before);
      failed_tests++;
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n_i     = 1'b0;
    pix_i       = '0;
    pix_valid_i = 1'b0;
    img_size_i  = vfilt_pkg::img_size_t'(16);

    run_test("fill_phase_w16", 16, 9, 1'b0, 1'b0);
    run_test("random_sums_w16", 16, 14, 1'b0, 1'b0);
    run_test("input_gaps_w16", 16, 14, 1'b1, 1'b0);
    run_test("row_length_w5", 5, 12, 1'b0, 1'b0);
    run_test("row_length_w37", 37, 11, 1'b0, 1'b0);
    run_test("full_scale_w16", 16, 10, 1'b0, 1'b1);

    $display("tests %0d, tests failed %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
